// ==== icache_pkg.sv ====
/*
 * Fixed geometry: 16 lines of 32 words, 20 bit tag from address bits 26:7.
 * Address bits 31:27 take no part in the tag, so such addresses alias.
 */
package icache_pkg;

    //----------------------------------------------------------------------
    // Geometry
    //----------------------------------------------------------------------
    localparam int ADDR_W     = 32;            // CPU and Wishbone byte address
    localparam int DATA_W     = 32;
    localparam int LINES      = 16;            // Cache lines
    localparam int LINE_WORDS = 32;            // Words per line
    localparam int TAG_L      = 7;             // Tag field low bit
    localparam int TAG_H      = 26;            // Tag field high bit
    localparam int TAG_W      = TAG_H - TAG_L + 1;
    localparam int WORD_W     = 5;             // Word in line
    localparam int INDEX_W    = 4;             // Line index
    localparam int RAM_AW     = INDEX_W + WORD_W; // {index, word}

    // Request width, same code points as the CPU fetch port
    typedef enum logic [1:0] {
        WIDTH_BYTE = 2'b00,
        WIDTH_HALF = 2'b01,
        WIDTH_WORD = 2'b10
    } width_e;

    // Controller FSM
    typedef enum logic [2:0] {
        IDLE        = 3'd0,
        TAG_COMPARE = 3'd1,
        REFILL_WAIT = 3'd2,
        RAM_READ    = 3'd3,
        RESPOND     = 3'd4
    } ctrl_state_e;

    //----------------------------------------------------------------------
    // Bundles
    //----------------------------------------------------------------------
    typedef struct packed {
        logic [ADDR_W-1:0] addr;  // Byte address
        width_e            width;
    } cpu_req_t;

    // Wishbone classic master side, we is always low so not carried
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic [ADDR_W-1:0] adr;
    } wb_req_t;

    typedef struct packed {
        logic              we;
        logic [RAM_AW-1:0] addr;
        logic [DATA_W-1:0] data;
    } ram_wr_t;

endpackage

// ==== icache_tag_fifo.sv ====
/*
 * Tag store for 16 lines, filled and overwritten in FIFO order.
 * Compare is combinational; a write is visible after the next edge.
 */
`timescale 1ns/10ps

module icache_tag_fifo import icache_pkg::*; (
    input  logic               mclk,
    input  logic               rst_n,
    input  logic [TAG_W-1:0]   lookup_tag_i,
    output logic               hit_o,
    output logic [INDEX_W-1:0] hit_index_o,
    input  logic               tag_wr_i,    // One cycle pulse from refill
    input  logic [TAG_W-1:0]   tag_wdata_i,
    output logic [INDEX_W-1:0] wr_index_o   // Line that the next refill fills
);

    logic [TAG_W-1:0]   tag_mem [LINES];
    logic [LINES-1:0]   valid_q;
    logic [INDEX_W-1:0] wr_ptr_q;

    assign wr_index_o = wr_ptr_q;

    //----------------------------------------------------------------------
    // Fill side
    //----------------------------------------------------------------------
    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q  <= '0;
            wr_ptr_q <= '0;
        end else if (tag_wr_i) begin
            valid_q[wr_ptr_q] <= 1'b1;
            wr_ptr_q          <= wr_ptr_q + 1'b1; // Wraps at 16, oldest goes first
        end
    end

    // Tag goes into the slot at the write pointer
    always_ff @(posedge mclk) begin
        if (tag_wr_i) begin
            tag_mem[wr_ptr_q] <= tag_wdata_i;
        end
    end

    //----------------------------------------------------------------------
    // Parallel compare
    //----------------------------------------------------------------------
    // A tag is only refilled on a miss, so at most one entry matches
    always_comb begin
        hit_o       = 1'b0;
        hit_index_o = '0;
        for (int i = 0; i < LINES; i++) begin
            if (valid_q[i] && (tag_mem[i] == lookup_tag_i)) begin
                hit_o       = 1'b1;
                hit_index_o = INDEX_W'(i);
            end
        end
    end

endmodule

// ==== icache_data_ram.sv ====
/*
 * Behavioral 512 x 32 cache RAM, one write port and one read port.
 * Contents are undefined after power up until a line is refilled.
 */
`timescale 1ns/10ps

module icache_data_ram import icache_pkg::*; (
    input  logic              mclk,
    input  ram_wr_t           wr_i,     // Refill write port
    input  logic [RAM_AW-1:0] raddr_i,  // {line index, word}
    output logic [DATA_W-1:0] rdata_o   // Valid one cycle after raddr_i
);

    logic [DATA_W-1:0] mem [2**RAM_AW];

    // Write port
    always_ff @(posedge mclk) begin
        if (wr_i.we) begin
            mem[wr_i.addr] <= wr_i.data;
        end
    end

    // Registered read, old data on a same address collision
    always_ff @(posedge mclk) begin
        rdata_o <= mem[raddr_i];
    end

endmodule

// ==== icache_refill.sv ====
/*
 * Line refill over Wishbone classic, 32 single reads with one idle stb cycle
 * between beats and cyc held for the whole line. No error handling, a beat
 * waits for ack indefinitely.
 */
`timescale 1ns/10ps

module icache_refill import icache_pkg::*; (
    input  logic               mclk,
    input  logic               rst_n,
    input  logic               start_i,       // Pulse, ignored while busy
    input  logic [ADDR_W-1:0]  line_addr_i,   // Bits 6:0 are don't care
    input  logic [INDEX_W-1:0] line_index_i,  // FIFO slot to fill
    output wb_req_t            wb_o,
    input  logic [DATA_W-1:0]  wb_dat_i,
    input  logic               wb_ack_i,
    output ram_wr_t            ram_wr_o,
    output logic               tag_wr_o,
    output logic [TAG_W-1:0]   tag_wdata_o,
    output logic               done_o         // Same cycle as tag_wr_o
);

    logic [ADDR_W-1:TAG_L] base_q;   // Line base, word bits implied
    logic [INDEX_W-1:0]    index_q;
    logic [WORD_W-1:0]     cnt_q;    // Current beat

    assign tag_wdata_o = base_q[TAG_H:TAG_L];

    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            wb_o     <= '0;
            ram_wr_o <= '0;
            tag_wr_o <= 1'b0;
            done_o   <= 1'b0;
            base_q   <= '0;
            index_q  <= '0;
            cnt_q    <= '0;
        end else begin
            ram_wr_o.we <= 1'b0;  // Pulses by default
            tag_wr_o    <= 1'b0;
            done_o      <= 1'b0;

            //--------------------------------------------------------------
            // Start of line, first beat at the base address
            //--------------------------------------------------------------
            if (start_i && !wb_o.cyc) begin
                base_q   <= line_addr_i[ADDR_W-1:TAG_L];
                index_q  <= line_index_i;
                cnt_q    <= '0;
                wb_o.cyc <= 1'b1;
                wb_o.stb <= 1'b1;
                wb_o.adr <= {line_addr_i[ADDR_W-1:TAG_L], {TAG_L{1'b0}}};
            end else if (wb_o.stb && wb_ack_i) begin
                // Beat ends, data taken at this edge
                wb_o.stb      <= 1'b0;
                ram_wr_o.we   <= 1'b1;
                ram_wr_o.addr <= {index_q, cnt_q};
                ram_wr_o.data <= wb_dat_i;
                if (cnt_q == WORD_W'(LINE_WORDS - 1)) begin
                    wb_o.cyc <= 1'b0;     // Line complete
                    tag_wr_o <= 1'b1;
                    done_o   <= 1'b1;
                end else begin
                    cnt_q <= cnt_q + 1'b1;
                end
            end else if (wb_o.cyc && !wb_o.stb) begin
                // Gap cycle over, next word
                wb_o.stb <= 1'b1;
                wb_o.adr <= {base_q, cnt_q, 2'b00};
            end
        end
    end

endmodule

// ==== icache_ctrl.sv ====
/*
 * CPU side controller, one outstanding read at a time.
 * Hit response comes 3 cycles after ack; a miss refills the line first.
 */
`timescale 1ns/10ps

module icache_ctrl import icache_pkg::*; (
    input  logic               mclk,
    input  logic               rst_n,
    input  logic               cpu_valid_i,
    input  cpu_req_t           cpu_req_i,
    output logic               cpu_ack_o,      // Request accepted, one cycle
    output logic               cpu_resp_o,     // Read data valid, one cycle
    output logic [DATA_W-1:0]  cpu_rdata_o,
    output logic [TAG_W-1:0]   lookup_tag_o,
    input  logic               hit_i,
    input  logic [INDEX_W-1:0] hit_index_i,
    output logic               refill_start_o,
    output logic [ADDR_W-1:0]  refill_addr_o,
    input  logic               refill_done_i,
    output logic [RAM_AW-1:0]  ram_raddr_o,
    input  logic [DATA_W-1:0]  ram_rdata_i
);

    ctrl_state_e state_q;
    cpu_req_t    req_q;    // Latched request

    // Pick the addressed lane and zero extend
    function automatic logic [DATA_W-1:0] align_rdata(
        input width_e            width,
        input logic [1:0]        addr_lo,
        input logic [DATA_W-1:0] word
    );
        logic [DATA_W-1:0] res;
        res = '0;
        case (width)
            WIDTH_BYTE: res[7:0]  = word[8*addr_lo +: 8];
            WIDTH_HALF: res[15:0] = word[16*addr_lo[1] +: 16];
            default:    res       = word;
        endcase
        return res;
    endfunction

    assign lookup_tag_o  = req_q.addr[TAG_H:TAG_L];
    assign refill_addr_o = {req_q.addr[ADDR_W-1:TAG_L], {TAG_L{1'b0}}}; // Line base

    //----------------------------------------------------------------------
    // FSM and handshake pulses
    //----------------------------------------------------------------------
    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            state_q        <= IDLE;
            cpu_ack_o      <= 1'b0;
            cpu_resp_o     <= 1'b0;
            refill_start_o <= 1'b0;
        end else begin
            cpu_ack_o      <= 1'b0;
            cpu_resp_o     <= 1'b0;
            refill_start_o <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (cpu_valid_i) begin
                        cpu_ack_o <= 1'b1;
                        state_q   <= TAG_COMPARE;
                    end
                end
                TAG_COMPARE: begin
                    if (hit_i) begin
                        state_q <= RAM_READ;
                    end else begin
                        refill_start_o <= 1'b1;   // Fetch the whole line
                        state_q        <= REFILL_WAIT;
                    end
                end
                REFILL_WAIT: begin
                    if (refill_done_i) begin
                        state_q <= TAG_COMPARE;   // Tag is valid at this edge
                    end
                end
                RAM_READ: state_q <= RESPOND;     // RAM read in flight
                RESPOND: begin
                    cpu_resp_o <= 1'b1;
                    state_q    <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    //----------------------------------------------------------------------
    // Datapath registers
    //----------------------------------------------------------------------
    always_ff @(posedge mclk) begin
        if (state_q == IDLE && cpu_valid_i) begin
            req_q <= cpu_req_i;
        end
        if (state_q == TAG_COMPARE && hit_i) begin
            ram_raddr_o <= {hit_index_i, req_q.addr[WORD_W+1:2]};
        end
        if (state_q == RESPOND) begin
            cpu_rdata_o <= align_rdata(req_q.width, req_q.addr[1:0], ram_rdata_i);
        end
    end

endmodule

// ==== icache_top.sv ====
/*
 * Read only instruction cache, CPU fetch port to Wishbone classic.
 * Data RAM is internal; no writes, flush or bypass.
 */
`timescale 1ns/10ps

module icache_top import icache_pkg::*; (
    input  logic              mclk,
    input  logic              rst_n,
    input  logic              cpu_valid_i,
    input  cpu_req_t          cpu_req_i,
    output logic              cpu_ack_o,
    output logic              cpu_resp_o,
    output logic [DATA_W-1:0] cpu_rdata_o,
    output wb_req_t           wb_o,
    input  logic [DATA_W-1:0] wb_dat_i,
    input  logic              wb_ack_i
);

    logic [TAG_W-1:0]   lookup_tag;
    logic               hit;
    logic [INDEX_W-1:0] hit_index;
    logic               refill_start;
    logic [ADDR_W-1:0]  refill_addr;
    logic               refill_done;
    logic [RAM_AW-1:0]  ram_raddr;
    logic [DATA_W-1:0]  ram_rdata;
    ram_wr_t            ram_wr;
    logic               tag_wr;
    logic [TAG_W-1:0]   tag_wdata;
    logic [INDEX_W-1:0] wr_index;    // FIFO slot for the next refill

    icache_ctrl i_ctrl (
        .mclk           (mclk),
        .rst_n          (rst_n),
        .cpu_valid_i    (cpu_valid_i),
        .cpu_req_i      (cpu_req_i),
        .cpu_ack_o      (cpu_ack_o),
        .cpu_resp_o     (cpu_resp_o),
        .cpu_rdata_o    (cpu_rdata_o),
        .lookup_tag_o   (lookup_tag),
        .hit_i          (hit),
        .hit_index_i    (hit_index),
        .refill_start_o (refill_start),
        .refill_addr_o  (refill_addr),
        .refill_done_i  (refill_done),
        .ram_raddr_o    (ram_raddr),
        .ram_rdata_i    (ram_rdata)
    );

    icache_tag_fifo i_tag_fifo (
        .mclk         (mclk),
        .rst_n        (rst_n),
        .lookup_tag_i (lookup_tag),
        .hit_o        (hit),
        .hit_index_o  (hit_index),
        .tag_wr_i     (tag_wr),
        .tag_wdata_i  (tag_wdata),
        .wr_index_o   (wr_index)
    );

    icache_refill i_refill (
        .mclk         (mclk),
        .rst_n        (rst_n),
        .start_i      (refill_start),
        .line_addr_i  (refill_addr),
        .line_index_i (wr_index),
        .wb_o         (wb_o),
        .wb_dat_i     (wb_dat_i),
        .wb_ack_i     (wb_ack_i),
        .ram_wr_o     (ram_wr),
        .tag_wr_o     (tag_wr),
        .tag_wdata_o  (tag_wdata),
        .done_o       (refill_done)
    );

    icache_data_ram i_data_ram (
        .mclk    (mclk),
        .wr_i    (ram_wr),
        .raddr_i (ram_raddr),
        .rdata_o (ram_rdata)
    );

endmodule

// ==== icache_props.sv ====
/*
 * CPU handshake and Wishbone classic rules, bound into icache_top.
 * The hit latency check uses the tag compare result of the ack cycle.
 */
`timescale 1ns/10ps

module icache_props import icache_pkg::*; (
    input logic    mclk,
    input logic    rst_n,
    input logic    cpu_ack_i,
    input logic    cpu_resp_i,
    input logic    hit_i,       // Valid while the controller is in TAG_COMPARE
    input wb_req_t wb_i,
    input logic    wb_ack_i
);

    int unsigned       fail_cnt = 0;  // Failed assertions so far
    logic [5:0]        beat_cnt;      // Acked beats in the current cycle
    logic [ADDR_W-1:0] last_adr;      // Address of the last acked beat

    task automatic record_failure(input string msg);
        $error("%s", msg);
        fail_cnt++;
    endtask

    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
            last_adr <= '0;
        end else if (!wb_i.cyc) begin
            beat_cnt <= '0;                 // Idle bus, next cycle counts from 0
        end else if (wb_i.stb && wb_ack_i) begin
            beat_cnt <= beat_cnt + 1'b1;
            last_adr <= wb_i.adr;
        end
    end

    //----------------------------------------------------------------------
    // Reset and CPU side
    //----------------------------------------------------------------------
    assert property (@(posedge mclk) $past(!rst_n) |->
                     (!cpu_ack_i && !cpu_resp_i && !wb_i.cyc && !wb_i.stb))
        else record_failure("outputs active right after reset");
    assert property (@(posedge mclk) disable iff (!rst_n)
                     $past(cpu_ack_i && hit_i, 3) |-> cpu_resp_i)
        else record_failure("hit response not 3 cycles after cpu_ack_o");
    // No bus cycle from the hit compare up to the response
    assert property (@(posedge mclk) disable iff (!rst_n)
                     ($past(cpu_ack_i && hit_i, 1) || $past(cpu_ack_i && hit_i, 2) ||
                      $past(cpu_ack_i && hit_i, 3)) |-> !wb_i.cyc)
        else record_failure("bus cycle opened during a hit");

    //----------------------------------------------------------------------
    // Wishbone master side
    //----------------------------------------------------------------------
    assert property (@(posedge mclk) disable iff (!rst_n) wb_i.stb |-> wb_i.cyc)
        else record_failure("stb high without cyc");
    assert property (@(posedge mclk) disable iff (!rst_n)
                     (wb_i.stb && !wb_ack_i) |=> (wb_i.stb && $stable(wb_i.adr)))
        else record_failure("stb or address changed during a wait state");
    assert property (@(posedge mclk) disable iff (!rst_n)
                     $rose(wb_i.cyc) |-> (wb_i.adr[TAG_L-1:0] == '0))
        else record_failure("first beat not at the line base");
    assert property (@(posedge mclk) disable iff (!rst_n)
                     (wb_i.cyc && $rose(wb_i.stb) && !$rose(wb_i.cyc)) |->
                     (wb_i.adr == last_adr + 32'd4))
        else record_failure("beat address not 4 above the previous beat");
    assert property (@(posedge mclk) disable iff (!rst_n)
                     $fell(wb_i.cyc) |-> (beat_cnt == 6'(LINE_WORDS)))
        else record_failure("refill did not run 32 beats");

endmodule

bind icache_top icache_props i_props (
    .mclk       (mclk),
    .rst_n      (rst_n),
    .cpu_ack_i  (cpu_ack_o),
    .cpu_resp_i (cpu_resp_o),
    .hit_i      (hit),
    .wb_i       (wb_o),
    .wb_ack_i   (wb_ack_i)
);

// ==== tb_icache.sv ====
/*
 * Testbench for icache_top, Wishbone memory returns A ^ MEM_PATTERN.
 * Address bits 31:27 stay zero, they alias in the tag.
 */
`timescale 1ns/10ps

module tb_icache import icache_pkg::*; ();

    localparam int          CLK_PERIOD   = 40;
    localparam int          RST_CYCLES   = 8;
    localparam logic [31:0] SEED         = 32'hb4356679;
    localparam int          ACK_TIMEOUT  = 16;   // Cycles
    localparam int          RESP_TIMEOUT = 600;  // Covers a refill at 3 wait states
    localparam logic [31:0] MEM_PATTERN  = 32'h5a3c_96e1;

    logic              mclk;
    logic              rst_n;
    logic              cpu_valid;
    cpu_req_t          cpu_req;
    logic              cpu_ack;
    logic              cpu_resp;
    logic [DATA_W-1:0] cpu_rdata;
    wb_req_t           wb_req;
    logic [DATA_W-1:0] wb_dat;
    logic              wb_ack;
    int unsigned       wait_left;  // Wait states left in this beat
    bit                refilled;   // Last read saw cyc high

    icache_top i_dut (
        .mclk        (mclk),
        .rst_n       (rst_n),
        .cpu_valid_i (cpu_valid),
        .cpu_req_i   (cpu_req),
        .cpu_ack_o   (cpu_ack),
        .cpu_resp_o  (cpu_resp),
        .cpu_rdata_o (cpu_rdata),
        .wb_o        (wb_req),
        .wb_dat_i    (wb_dat),
        .wb_ack_i    (wb_ack)
    );

    initial begin
        mclk = 1'b0;
        forever #(CLK_PERIOD / 2) mclk = ~mclk;
    end

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    //----------------------------------------------------------------------
    // Wishbone slave, 0 to 3 wait states per beat
    //----------------------------------------------------------------------
    initial begin
        wb_dat    = '0;
        wb_ack    = 1'b0;
        wait_left = 0;
        forever begin
            @(negedge mclk);
            if (wb_ack) begin
                wb_ack    = 1'b0;          // Beat ended at the last edge
                wait_left = $urandom % 4;
            end else if (wb_req.cyc && wb_req.stb) begin
                if (wait_left == 0) begin
                    wb_ack = 1'b1;
                    wb_dat = wb_req.adr ^ MEM_PATTERN;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    // Zero extended lane of the memory word
    function automatic logic [DATA_W-1:0] expected_data(input logic [ADDR_W-1:0] a,
                                                        input width_e w);
        logic [DATA_W-1:0] word;
        word = {a[ADDR_W-1:2], 2'b00} ^ MEM_PATTERN;
        case (w)
            WIDTH_BYTE: return (word >> (8 * a[1:0])) & 32'h0000_00ff;
            WIDTH_HALF: return (word >> (16 * a[1])) & 32'h0000_ffff;
            default:    return word;
        endcase
    endfunction

    function automatic logic [ADDR_W-1:0] random_addr(input int k);
        return 32'h0010_0000 + 32'(k) * 32'h0000_1380 + ADDR_W'($urandom % 128);
    endfunction

    function automatic width_e random_width();
        case ($urandom % 3)
            0:       return WIDTH_BYTE;
            1:       return WIDTH_HALF;
            default: return WIDTH_WORD;
        endcase
    endfunction

    // One request, held until ack, then checked at the response pulse
    task automatic read_check(input logic [ADDR_W-1:0] a, input width_e w);
        int                n;
        logic [DATA_W-1:0] exp;
        exp      = expected_data(a, w);
        refilled = 1'b0;
        @(negedge mclk);
        cpu_req.addr  = a;
        cpu_req.width = w;
        cpu_valid     = 1'b1;
        n = 0;
        @(negedge mclk);
        while (!cpu_ack) begin
            n++;
            if (n > ACK_TIMEOUT) fail_run("timeout waiting for cpu_ack_o");
            @(negedge mclk);
        end
        cpu_valid = 1'b0;
        n = 0;
        @(negedge mclk);
        while (!cpu_resp) begin
            refilled = refilled | wb_req.cyc;
            n++;
            if (n > RESP_TIMEOUT) fail_run("timeout waiting for cpu_resp_o");
            @(negedge mclk);
        end
        assert (cpu_rdata == exp) else
            fail_run($sformatf("mismatch at %0t: addr %h %s read %h expected %h",
                               $time, a, w.name(), cpu_rdata, exp));
    endtask

    // Failed protocol assertions end the run
    always @(negedge mclk) begin
        if (i_dut.i_props.fail_cnt != 0) fail_run("protocol assertion failed in icache_props");
    end

    //----------------------------------------------------------------------
    // Stimulus
    //----------------------------------------------------------------------
    initial begin
        cpu_valid = 1'b0;
        cpu_req   = '0;
        rst_n     = 1'b0;
        void'($urandom(SEED));
        repeat (RST_CYCLES) @(negedge mclk);
        rst_n = 1'b1;

        read_check(32'h0010_0008, WIDTH_WORD);   // Cold miss, line 0
        assert (refilled) else fail_run("first read of line 0 did not start a refill");
        read_check(32'h0010_0050, WIDTH_WORD);   // Same line, other word
        assert (!refilled) else fail_run("hit on line 0 started a refill");
        for (int lo = 0; lo < 4; lo++) begin
            read_check(32'h0010_0000 + ADDR_W'(($urandom % 32) * 4 + lo), WIDTH_BYTE);
            read_check(32'h0010_0000 + ADDR_W'(($urandom % 32) * 4 + lo), WIDTH_HALF);
        end

        // 16 newer lines push line 0 out of the FIFO
        for (int k = 1; k <= LINES; k++) read_check(random_addr(k), random_width());
        read_check(random_addr(0), random_width());
        assert (refilled) else fail_run("line 0 still cached after 16 newer lines");
        read_check(random_addr(LINES), random_width());
        assert (!refilled) else fail_run("line 16 was refilled although cached");
        repeat (24) read_check(random_addr($urandom % 17), random_width());

        repeat (4) @(negedge mclk);
        if (i_dut.i_props.fail_cnt == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            fail_run("protocol assertion failed in icache_props");
        end
    end

endmodule

// ==== tb.f ====
icache_pkg.sv
icache_tag_fifo.sv
icache_data_ram.sv
icache_refill.sv
icache_ctrl.sv
icache_top.sv
icache_props.sv
tb_icache.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       ?= tb_icache
FILELIST  ?= tb.f
SIM_FLAGS ?= +verilator+error+limit+100
PASS_MSG  := All checks passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP) $(SIM_FLAGS) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
